/* Makefile */
# Verilator build and regression run for the AHB to APB bridge.
SIM ?= verilator
TOP ?= bridge_tb
LOG ?= sim.log
OBJDIR ?= obj_dir
SIMFLAGS ?= --binary --timing --assert --timescale 1ns/1ns

SRCS := $(filter %.sv %.v,$(shell cat src.f))
HDRS := bridge_consts.svh
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run check clean

all: run

$(OBJDIR)/V%: $(SRCS) $(HDRS) src.f
	$(SIM) $(SIMFLAGS) -f src.f --top-module $* -Mdir $(OBJDIR)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -q "Regression failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* ahbApbBridge.sv */
// AHB-Lite to APB bridge top; no error response, single-word transfers only.
`timescale 1ns/1ns
`include "bridge_consts.svh"

module ahbApbBridge
	import bridge_pkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input addr_t hAddr,
	input logic hWrite,
	input trans_t hTrans,
	input data_t hWdata,
	input logic hSel,
	output data_t hRdata,
	output logic hReadyOut
);

	logic valid;
	logic hWriteReg;
	logic pWrite;
	logic pEnable;
	addr_t hAddr1;
	addr_t hAddr2;
	addr_t pAddr;
	data_t hWdata1;
	data_t hWdata2;
	data_t pWdata;
	sel_t tempSel;
	sel_t pSel;
	rdataBus_t pRdataBus;

	ahbSlaveInterface uAhbIf (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.hAddr(hAddr),
		.hWdata(hWdata),
		.hWrite(hWrite),
		.hTrans(hTrans),
		.hSel(hSel),
		.hReadyIn(hReadyOut),
		.pSel(pSel),
		.pRdataBus(pRdataBus),
		.valid(valid),
		.hAddr1(hAddr1),
		.hAddr2(hAddr2),
		.hWdata1(hWdata1),
		.hWdata2(hWdata2),
		.hWriteReg(hWriteReg),
		.tempSel(tempSel),
		.hRdata(hRdata)
	);

	apbFsmController uApbFsm (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.valid(valid),
		.hAddr(hAddr),
		.hAddr1(hAddr1),
		.hAddr2(hAddr2),
		.hWdata(hWdata),
		.hWdata1(hWdata1),
		.hWdata2(hWdata2),
		.hWrite(hWrite),
		.hWriteReg(hWriteReg),
		.tempSel(tempSel),
		.pWrite(pWrite),
		.pEnable(pEnable),
		.pSel(pSel),
		.pAddr(pAddr),
		.pWdata(pWdata),
		.hReadyOut(hReadyOut)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Peripherals.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar i = 0; i < `NUM_SLAVES; i++)
	begin : genSlave
		apbRegSlave uSlave (
			.Hclk(Hclk),
			.Hresetn(Hresetn),
			.pSel(pSel[i]),
			.pEnable(pEnable),
			.pWrite(pWrite),
			.pAddr(pAddr),
			.pWdata(pWdata),
			.pRdata(pRdataBus[i*32 +: 32])
		);
	end

endmodule

/* ahbSlaveInterface.sv */
// AHB-Lite slave side; assumes the master holds address and data while hReadyIn is low.
`timescale 1ns/1ns
`include "bridge_consts.svh"

module ahbSlaveInterface
	import bridge_pkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input addr_t hAddr,
	input data_t hWdata,
	input logic hWrite,
	input trans_t hTrans,
	input logic hSel,
	input logic hReadyIn,
	input sel_t pSel,
	input rdataBus_t pRdataBus,
	output logic valid,
	output addr_t hAddr1,
	output addr_t hAddr2,
	output data_t hWdata1,
	output data_t hWdata2,
	output logic hWriteReg,
	output sel_t tempSel,
	output data_t hRdata
);

	logic activeTrans;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address phase decode.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign activeTrans = (hTrans == `TRANS_NONSEQ) || (hTrans == `TRANS_SEQ);
	assign tempSel = decodeSel(hAddr);
	assign valid = hSel && hReadyIn && activeTrans && (|tempSel);

	// Address and data history, one and two cycles old.
	always_ff @(posedge Hclk)
	begin
		hAddr1 <= hAddr;
		hAddr2 <= hAddr1;
		hWdata1 <= hWdata;
		hWdata2 <= hWdata1;
	end

	// Direction of the last accepted phase.
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			hWriteReg <= 1'b0;
		else if (hReadyIn)
			hWriteReg <= hWrite;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read data return.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		hRdata = '0;
		for (int i = 0; i < `NUM_SLAVES; i++)
		begin
			if (pSel[i])
				hRdata = hRdata | pRdataBus[i*32 +: 32];
		end
	end

endmodule

/* apbFsmController.sv */
// APB master FSM; peripherals never stretch the access cycle, so pReady is not sampled.
`timescale 1ns/1ns
`include "bridge_consts.svh"

module apbFsmController
	import bridge_pkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic valid,
	input addr_t hAddr,
	input addr_t hAddr1,
	input addr_t hAddr2,
	input data_t hWdata,
	input data_t hWdata1,
	input data_t hWdata2,
	input logic hWrite,
	input logic hWriteReg,
	input sel_t tempSel,
	output logic pWrite,
	output logic pEnable,
	output sel_t pSel,
	output addr_t pAddr,
	output data_t pWdata,
	output logic hReadyOut
);

	apbState_t state;
	apbState_t nextState;
	logic pWriteNext;
	logic pEnableNext;
	logic hReadyNext;
	sel_t pSelNext;
	addr_t pAddrNext;
	data_t pWdataNext;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			state <= stIdle;
		else
			state <= nextState;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next state and next APB outputs.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		nextState = state;
		pWriteNext = pWrite;
		pEnableNext = pEnable;
		pSelNext = pSel;
		pAddrNext = pAddr;
		pWdataNext = pWdata;
		hReadyNext = hReadyOut;
		case (state)
			stIdle, stREnable, stWEnable:
			begin
				pSelNext = '0;
				pEnableNext = 1'b0;
				hReadyNext = 1'b1;
				nextState = stIdle;
				if (valid && hWrite)
					nextState = stWwait;
				else if (valid)
				begin
					// Read setup straight from the live address phase.
					nextState = stRead;
					pSelNext = tempSel;
					pAddrNext = hAddr;
					pWriteNext = 1'b0;
					hReadyNext = 1'b0;
				end
			end
			stWwait:
			begin
				nextState = valid ? stWriteP : stWrite;
				pSelNext = decodeSel(hAddr1);
				pAddrNext = hAddr1;
				pWdataNext = hWdata;
				pWriteNext = 1'b1;
				pEnableNext = 1'b0;
				hReadyNext = 1'b0;
			end
			stRead:
			begin
				nextState = stREnable;
				pEnableNext = 1'b1;
				hReadyNext = 1'b1;
			end
			stWrite:
			begin
				nextState = valid ? stWEnableP : stWEnable;
				pEnableNext = 1'b1;
				hReadyNext = 1'b1;
			end
			stWriteP:
			begin
				// A pending read must not complete before its data exists.
				nextState = stWEnableP;
				pEnableNext = 1'b1;
				hReadyNext = hWriteReg;
			end
			stWEnableP:
			begin
				pSelNext = decodeSel(hAddr2);
				pAddrNext = hAddr2;
				pWriteNext = hWriteReg;
				pEnableNext = 1'b0;
				hReadyNext = 1'b0;
				if (hWriteReg)
				begin
					pWdataNext = hWdata1;
					nextState = valid ? stWriteP : stWrite;
				end
				else
					nextState = stRead;
			end
			default:
				nextState = stIdle;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registered outputs.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			pWrite <= 1'b0;
			pEnable <= 1'b0;
			pSel <= '0;
			hReadyOut <= 1'b0;
		end
		else
		begin
			pWrite <= pWriteNext;
			pEnable <= pEnableNext;
			pSel <= pSelNext;
			hReadyOut <= hReadyNext;
		end
	end

	// APB address and write data.
	always_ff @(posedge Hclk)
	begin
		pAddr <= pAddrNext;
		pWdata <= pWdataNext;
	end

endmodule

/* apbRegSlave.sv */
// APB register peripheral; zero wait states and word accesses only.
`timescale 1ns/1ns
`include "bridge_consts.svh"

module apbRegSlave
	import bridge_pkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input addr_t pAddr,
	input data_t pWdata,
	output data_t pRdata
);

	localparam int IDX_W = $clog2(`REGS_PER_SLAVE);

	data_t regs [`REGS_PER_SLAVE];
	logic [IDX_W-1:0] idx;

	// Word index from the byte address.
	assign idx = pAddr[IDX_W+1:2];

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			for (int i = 0; i < `REGS_PER_SLAVE; i++)
				regs[i] <= '0;
		end
		else if (pSel && pEnable && pWrite)
			regs[idx] <= pWdata;
	end

	assign pRdata = regs[idx];

endmodule

/* bridge_consts.svh */
// Address map and AHB transfer codes; windows must not overlap and must fit below 2**32.
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral map.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NUM_SLAVES 3
`define REGS_PER_SLAVE 4
`define SLAVE_BASE 32'h8000_0000
`define SLAVE_SPAN 32'h0400_0000

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB HTRANS encodings.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define TRANS_IDLE 2'b00
`define TRANS_BUSY 2'b01
`define TRANS_NONSEQ 2'b10
`define TRANS_SEQ 2'b11

`endif

/* bridge_pkg.sv */
// Bridge types and address decode; all data paths are fixed at 32 bits.
`include "bridge_consts.svh"

package bridge_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [`NUM_SLAVES-1:0] sel_t;
	typedef logic [1:0] trans_t;
	typedef logic [`NUM_SLAVES*32-1:0] rdataBus_t;

	typedef enum logic [2:0] {
		stIdle,
		stWwait,
		stRead,
		stWrite,
		stWriteP,
		stREnable,
		stWEnable,
		stWEnableP
	} apbState_t;

	// One-hot window match, zero when the address hits no peripheral.
	function automatic sel_t decodeSel(addr_t addr);
		sel_t sel;
		addr_t lo;
		sel = '0;
		for (int i = 0; i < `NUM_SLAVES; i++)
		begin
			lo = `SLAVE_BASE + addr_t'(i) * `SLAVE_SPAN;
			if (addr >= lo && addr < lo + `SLAVE_SPAN)
				sel[i] = 1'b1;
		end
		return sel;
	endfunction

endpackage

/* bridge_properties.sv */
// Bound checks on the APB controller; assumes every access completes in one enable cycle.
`timescale 1ns/1ns

module bridgeProperties
	import bridge_pkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input apbState_t state,
	input logic pEnable,
	input sel_t pSel
);

	// Synchronous reset lands in idle.
	resetToIdle: assert property (@(posedge Hclk) !Hresetn |=> state == stIdle)
		else $error("FSM not in stIdle after reset");

	readThenEnable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		state == stRead |=> state == stREnable)
		else $error("stRead not followed by stREnable");

	// Access cycle only after a setup cycle to the same peripheral.
	enableAfterSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
		pEnable |-> (|pSel) && $past(pSel) == pSel && !$past(pEnable))
		else $error("pEnable without a matching setup cycle");

	selOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(pSel))
		else $error("pSel selects more than one peripheral");

endmodule

bind apbFsmController bridgeProperties uProps (
	.Hclk(Hclk),
	.Hresetn(Hresetn),
	.state(state),
	.pEnable(pEnable),
	.pSel(pSel)
);

/* bridge_tb.sv */
// Self-checking testbench; the AHB master drives on the falling edge and holds while hReadyOut is low.
`timescale 1ns/1ns
`include "bridge_consts.svh"

module bridge_tb
	import bridge_pkg::*;
();

	localparam int NUM_REGS = `NUM_SLAVES * `REGS_PER_SLAVE;
	localparam int RANDOM_WRITES = 24;
	localparam int MIXED_PAIRS = 24;
	localparam int BAD_ROUNDS = 4;
	localparam int TRANSFERS = 7 * NUM_REGS + RANDOM_WRITES + 2 * MIXED_PAIRS + 4 * BAD_ROUNDS + 20;
	localparam int TIMEOUT_CYCLES = TRANSFERS * 10 + 100;

	logic Hclk;
	logic Hresetn;
	addr_t hAddr;
	logic hWrite;
	trans_t hTrans;
	data_t hWdata;
	logic hSel;
	data_t hRdata;
	logic hReadyOut;

	data_t shadow [`NUM_SLAVES][`REGS_PER_SLAVE] = '{default: '0};
	data_t expQ[$];
	data_t actQ[$];
	string msgQ[$];
	int errorCount = 0;
	int checkedCount = 0;
	logic pendWrite = 1'b0;
	logic pendRead = 1'b0;
	data_t pendData = '0;

	ahbApbBridge uut (.*);

	initial
	begin
		Hclk = 1'b0;
		forever #4 Hclk = ~Hclk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic inWindow(input addr_t addr);
		return addr >= `SLAVE_BASE && addr < `SLAVE_BASE + `NUM_SLAVES * `SLAVE_SPAN;
	endfunction

	function automatic data_t refRead(input addr_t addr);
		if (!inWindow(addr))
			return '0;
		return shadow[(addr - `SLAVE_BASE) / `SLAVE_SPAN][addr[3:2]];
	endfunction

	function automatic addr_t regAddr(input int slave, input int idx, input addr_t offset);
		return `SLAVE_BASE + addr_t'(slave) * `SLAVE_SPAN + offset + addr_t'(idx) * 4;
	endfunction

	// Random 16-byte aligned offset inside a window.
	function automatic addr_t rndOffset();
		return addr_t'($urandom % (`SLAVE_SPAN / 16)) * 16;
	endfunction

	task automatic checkValue(input data_t actual, input data_t expected, input string msg);
		if (actual !== expected)
		begin
			errorCount++;
			$display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
		end
	endtask

	task automatic queueCheck(input data_t actual, input data_t expected, input string msg);
		expQ.push_back(expected);
		actQ.push_back(actual);
		msgQ.push_back(msg);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AHB master.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic busPhase(input addr_t addr, input logic write, input trans_t trans,
		input logic sel, input data_t data);
		logic ok;
		ok = sel && (trans == `TRANS_NONSEQ || trans == `TRANS_SEQ) && inWindow(addr);
		@(negedge Hclk);
		if (pendWrite)
			hWdata = pendData;
		hAddr = addr;
		hWrite = write;
		hTrans = trans;
		hSel = sel;
		while (!hReadyOut)
			@(negedge Hclk);
		// Previous data phase ends here, this address phase is taken.
		if (pendRead)
			actQ.push_back(hRdata);
		if (ok && write)
			shadow[(addr - `SLAVE_BASE) / `SLAVE_SPAN][addr[3:2]] = data;
		if (ok && !write)
		begin
			expQ.push_back(refRead(addr));
			msgQ.push_back($sformatf("read of %h", addr));
		end
		pendWrite = write;
		pendRead = ok && !write;
		pendData = data;
	endtask

	task automatic writeWord(input addr_t addr, input data_t data);
		busPhase(addr, 1'b1, `TRANS_NONSEQ, 1'b1, data);
	endtask

	task automatic readWord(input addr_t addr);
		busPhase(addr, 1'b0, `TRANS_NONSEQ, 1'b1, '0);
	endtask

	task automatic idleCycle();
		busPhase('0, 1'b0, `TRANS_IDLE, 1'b0, '0);
	endtask

	task automatic readAll();
		for (int s = 0; s < `NUM_SLAVES; s++)
			for (int r = 0; r < `REGS_PER_SLAVE; r++)
				readWord(regAddr(s, r, rndOffset()));
		idleCycle();
	endtask

	// Compare in order of completion.
	always @(posedge Hclk)
	begin
		while (checkedCount < actQ.size())
		begin
			checkValue(actQ[checkedCount], expQ[checkedCount], msgQ[checkedCount]);
			checkedCount++;
		end
	end

	initial
	begin
		int s1;
		int s2;
		addr_t a;
		data_t d;
		void'($urandom(74));
		Hresetn = 1'b0;
		hAddr = '0;
		hWrite = 1'b0;
		hTrans = `TRANS_IDLE;
		hWdata = '0;
		hSel = 1'b0;
		repeat (5) @(posedge Hclk);
		@(negedge Hclk);
		queueCheck(data_t'(hReadyOut), 0, "hReadyOut in reset");
		Hresetn = 1'b1;
		@(negedge Hclk);
		queueCheck(data_t'(hReadyOut), 1, "hReadyOut after reset");
		queueCheck(data_t'(uut.pSel), 0, "pSel after reset");
		readAll();

		// Single write then read of each register.
		for (int s = 0; s < `NUM_SLAVES; s++)
			for (int r = 0; r < `REGS_PER_SLAVE; r++)
			begin
				a = regAddr(s, r, rndOffset());
				d = $urandom;
				writeWord(a, d);
				idleCycle();
				readWord(a);
				idleCycle();
			end

		// Back-to-back writes through the pipelined states.
		for (int k = 0; k < RANDOM_WRITES; k++)
		begin
			a = regAddr(int'($urandom % `NUM_SLAVES), int'($urandom % `REGS_PER_SLAVE), rndOffset());
			busPhase(a, 1'b1, (k % 4 == 0) ? `TRANS_NONSEQ : `TRANS_SEQ, 1'b1, $urandom);
		end
		readAll();

		repeat (MIXED_PAIRS)
		begin
			s1 = int'($urandom % `NUM_SLAVES);
			s2 = (s1 + 1 + int'($urandom % 2)) % `NUM_SLAVES;
			writeWord(regAddr(s1, int'($urandom % `REGS_PER_SLAVE), rndOffset()), $urandom);
			readWord(regAddr(s2, int'($urandom % `REGS_PER_SLAVE), rndOffset()));
		end
		idleCycle();

		// Writes that must be ignored.
		repeat (BAD_ROUNDS)
		begin
			a = regAddr(int'($urandom % `NUM_SLAVES), int'($urandom % `REGS_PER_SLAVE), '0);
			busPhase(a, 1'b1, `TRANS_IDLE, 1'b1, $urandom);
			busPhase(a, 1'b1, `TRANS_NONSEQ, 1'b0, $urandom);
			busPhase(`SLAVE_BASE - 32'h10 + a[3:0], 1'b1, `TRANS_NONSEQ, 1'b1, $urandom);
			busPhase(regAddr(`NUM_SLAVES, 0, a[3:0]), 1'b1, `TRANS_NONSEQ, 1'b1, $urandom);
		end
		readAll();

		idleCycle();
		repeat (2) @(posedge Hclk);
		$display("Errors: %0d, checks done: %0d of %0d", errorCount, checkedCount, expQ.size());
		if (errorCount == 0 && checkedCount == expQ.size())
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge Hclk);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Regression failed");
		$finish;
	end

endmodule

/* src.f */
+incdir+.
bridge_pkg.sv
ahbSlaveInterface.sv
apbFsmController.sv
apbRegSlave.sv
ahbApbBridge.sv
bridge_properties.sv
bridge_tb.sv
